//--- src.f
lsu_pkg.sv
reg_file.sv
data_memory.sv
lsu_exec.sv
lsu_top.sv
tb_clock.sv
tb_lsu.sv

//--- data.mem
// data memory preload, one hex byte per token
// each line is one big-endian word, lowest address first, starting at address 0
12 34 56 78
9a bc de f0
80 7f ff 01
00 00 00 00
ca fe 00 7e
81 02 c3 44
55 a6 77 f8
de ad be ef
01 23 45 67
89 ab cd ef
fe dc ba 98
76 54 32 10
a5 5a 0f f0
33 cc 99 66

//--- tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu;

    import lsu_pkg::*;

    localparam int MEM_BYTES   = 1024;
    localparam int RSP_TIMEOUT = 20; // cycles

    logic      clk;
    logic      reset;
    logic      cmd_valid;
    lsu_cmd_t  cmd;
    logic      rsp_valid;
    lsu_rsp_t  rsp;

    logic [7:0]  model_mem [MEM_BYTES];
    logic [31:0] model_regs [8];
    lsu_cmd_t    burst_cmds [5];
    lsu_rsp_t    burst_exp [5];
    integer      seed;
    int          error_count;
    int          check_count;
    int          test_count;
    int          errors_before;

    tb_clock #(.PERIOD_NS(40)) u_clock (.clk_o(clk));

    lsu_top #(
        .MEM_BYTES (MEM_BYTES),
        .REG_COUNT (8)
    ) u_dut (
        .clk_i       (clk),
        .reset_i     (reset),
        .cmd_valid_i (cmd_valid),
        .cmd_i       (cmd),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp)
    );

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    function automatic lsu_cmd_t mk_cmd(input lsu_op_e op, input int rd, input int rs1,
                                        input int rs2, input int off);
        lsu_cmd_t c;
        c.op     = op;
        c.rd     = rd[2:0];
        c.rs1    = rs1[2:0];
        c.rs2    = rs2[2:0];
        c.offset = off[15:0];
        return c;
    endfunction

    // reference model of one command, applied in issue order
    task automatic model_step(input lsu_cmd_t c, output lsu_rsp_t r);
        int          imm;
        logic [31:0] ea;
        int          span;
        logic        bad;
        imm  = c.offset; // signed offset widens with its sign
        ea   = model_regs[c.rs1] + imm;
        span = (c.op == OP_LW || c.op == OP_SW) ? 4 : 1;
        bad  = (c.op != OP_LI) &&
               (((span == 4) && (ea % 4 != 0)) ||
                (longint'({32'd0, ea}) + span > MEM_BYTES));
        r.rd    = c.rd;
        r.addr  = (c.op == OP_LI) ? 32'd0 : ea;
        r.fault = bad;
        r.data  = 32'd0;
        case (c.op)
            OP_LI:  r.data = imm;
            OP_LB:  if (!bad) r.data = int'($signed(model_mem[ea]));
            OP_LBU: if (!bad) r.data = {24'd0, model_mem[ea]};
            OP_LW:  if (!bad) r.data = {model_mem[ea], model_mem[ea + 1],
                                        model_mem[ea + 2], model_mem[ea + 3]};
            OP_SB: begin
                if (!bad) begin
                    r.data        = model_regs[c.rs2];
                    model_mem[ea] = r.data[7:0];
                end
            end
            OP_SW: begin
                if (!bad) begin
                    r.data            = model_regs[c.rs2];
                    model_mem[ea]     = r.data[31:24];
                    model_mem[ea + 1] = r.data[23:16];
                    model_mem[ea + 2] = r.data[15:8];
                    model_mem[ea + 3] = r.data[7:0];
                end
            end
            default: ;
        endcase
        if (c.rd != 0 && !bad && c.op inside {OP_LI, OP_LB, OP_LBU, OP_LW}) begin
            model_regs[c.rd] = r.data;
        end
    endtask

    task automatic compare_rsp(input lsu_cmd_t c, input lsu_rsp_t e);
        check_value("rsp rd", rsp.rd, e.rd);
        check_value("rsp data", rsp.data, e.data);
        check_value("rsp fault", rsp.fault, e.fault);
        if (c.op != OP_LI) begin
            check_value("rsp addr", rsp.addr, e.addr);
        end
    endtask

    task automatic wait_rsp();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!rsp_valid && cycles < RSP_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!rsp_valid) begin
            $display("ERROR: no response within %0d cycles at %0t", RSP_TIMEOUT, $time);
            $display("Test failures found");
            $finish;
        end
    endtask

    task automatic run_cmd(input lsu_cmd_t c);
        lsu_rsp_t exp;
        model_step(c, exp);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd       <= c;
        @(posedge clk);
        cmd_valid <= 1'b0;
        wait_rsp();
        compare_rsp(c, exp);
    endtask

    // strobes on consecutive edges with each response due exactly 2 cycles later
    task automatic run_burst(input int n);
        for (int cyc = 0; cyc < n + 3; cyc++) begin
            @(posedge clk);
            if (cyc < n) begin
                model_step(burst_cmds[cyc], burst_exp[cyc]);
                cmd_valid <= 1'b1;
                cmd       <= burst_cmds[cyc];
            end else begin
                cmd_valid <= 1'b0;
            end
            @(negedge clk);
            if (cyc >= 2 && cyc < n + 2) begin
                check_value("rsp_valid", rsp_valid, 1'b1);
                compare_rsp(burst_cmds[cyc - 2], burst_exp[cyc - 2]);
            end else begin
                check_value("rsp_valid", rsp_valid, 1'b0);
            end
        end
    endtask

    task automatic end_test(input string name);
        $display("[%0t] %s finished, %0d errors", $time, name, error_count - errors_before);
        errors_before = error_count;
        test_count++;
    endtask

    task automatic test_li_and_x0();
        for (int k = 1; k < 8; k++) begin
            run_cmd(mk_cmd(OP_LI, k, 0, 0, 4 * k)); // preloaded word addresses
        end
        run_cmd(mk_cmd(OP_LI, 0, 0, 0, 16'h10));
        for (int k = 1; k < 8; k++) begin
            run_cmd(mk_cmd(OP_LW, k, k, 0, 0)); // addr shows the LI value
        end
        run_cmd(mk_cmd(OP_LW, 1, 0, 0, 8)); // x0 still reads zero
        end_test("load immediate and x0");
    endtask

    task automatic test_preload_loads();
        for (int a = 0; a < 56; a += 4) begin
            run_cmd(mk_cmd(OP_LW, 1 + (a / 4) % 7, 0, 0, a));
        end
        for (int a = 0; a < 24; a++) begin
            run_cmd(mk_cmd(OP_LB, 2, 0, 0, a));
            run_cmd(mk_cmd(OP_LBU, 3, 0, 0, a));
        end
        end_test("preloaded loads");
    endtask

    task automatic test_store_load();
        int addr;
        int lane;
        for (int i = 0; i < 4; i++) begin
            addr = 256 + ($random(seed) & 32'h1fc);
            lane = $random(seed) & 3;
            if (i % 2 == 1) begin
                run_cmd(mk_cmd(OP_LW, 2, 0, 0, $random(seed) & 32'h30)); // full word
            end else begin
                run_cmd(mk_cmd(OP_LI, 2, 0, 0, $random(seed)));
            end
            run_cmd(mk_cmd(OP_LI, 1, 0, 0, addr + 8));
            run_cmd(mk_cmd(OP_SW, 0, 1, 2, -8)); // negative offset
            run_cmd(mk_cmd(OP_LW, 3, 0, 0, addr));
            run_cmd(mk_cmd(OP_LI, 4, 0, 0, $random(seed)));
            run_cmd(mk_cmd(OP_SB, 0, 0, 4, addr + lane));
            run_cmd(mk_cmd(OP_LW, 5, 0, 0, addr));
            for (int b = -1; b < 5; b++) begin
                run_cmd(mk_cmd(OP_LBU, 6, 0, 0, addr + b)); // neighbours too
            end
            run_cmd(mk_cmd(OP_LB, 7, 0, 0, addr + lane));
        end
        end_test("store then load");
    endtask

    task automatic test_faults();
        run_cmd(mk_cmd(OP_LI, 6, 0, 0, 32'h100));
        run_cmd(mk_cmd(OP_LW, 6, 0, 0, 5));      // word at 4n+1
        run_cmd(mk_cmd(OP_LW, 7, 6, 0, 0));      // r6 kept its value
        run_cmd(mk_cmd(OP_LI, 2, 0, 0, -2));
        run_cmd(mk_cmd(OP_SW, 0, 6, 2, 1));      // misaligned store
        run_cmd(mk_cmd(OP_SW, 0, 0, 2, MEM_BYTES));
        run_cmd(mk_cmd(OP_SB, 0, 0, 2, MEM_BYTES));
        run_cmd(mk_cmd(OP_LB, 3, 0, 0, MEM_BYTES));
        run_cmd(mk_cmd(OP_LB, 3, 0, 0, MEM_BYTES - 1)); // last byte is legal
        run_cmd(mk_cmd(OP_LW, 3, 0, 0, MEM_BYTES - 4));
        run_cmd(mk_cmd(OP_LI, 1, 0, 0, MEM_BYTES - 4));
        run_cmd(mk_cmd(OP_LW, 4, 1, 0, 4));      // aligned but past the end
        run_cmd(mk_cmd(OP_LBU, 3, 0, 0, -1));    // wraps to the top
        run_cmd(mk_cmd(OP_LW, 4, 6, 0, 0));      // memory left unchanged
        run_cmd(mk_cmd(OP_LBU, 4, 6, 0, 1));
        end_test("faults");
    endtask

    task automatic test_back_to_back();
        run_cmd(mk_cmd(OP_LI, 1, 0, 0, 32'h200));
        run_cmd(mk_cmd(OP_LI, 2, 0, 0, 32'h5a5));
        burst_cmds[0] = mk_cmd(OP_SW, 0, 1, 2, 0);
        burst_cmds[1] = mk_cmd(OP_LW, 3, 1, 0, 0);  // sees the store
        burst_cmds[2] = mk_cmd(OP_LI, 4, 0, 0, 32'h204);
        burst_cmds[3] = mk_cmd(OP_LW, 5, 4, 0, -4); // base from the LI just before
        burst_cmds[4] = mk_cmd(OP_LBU, 6, 1, 0, 3);
        run_burst(5);
        end_test("back to back");
    endtask

    initial begin
        seed          = 32'hc42e;
        error_count   = 0;
        check_count   = 0;
        test_count    = 0;
        errors_before = 0;
        reset         = 1'b1;
        cmd_valid     = 1'b0;
        cmd           = '0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            model_mem[i] = 8'h00;
        end
        $readmemh("data.mem", model_mem);
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = 32'd0;
        end

        repeat (3) @(posedge clk);
        reset <= 1'b0;

        test_li_and_x0();
        test_preload_loads();
        test_store_load();
        test_faults();
        test_back_to_back();

        $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o; // free running

endmodule

//--- lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
    parameter int MEM_BYTES = 1024, // multiple of 4
    parameter int REG_COUNT = 8     // must match REG_ADDR_W
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              cmd_valid_i,
    input  lsu_pkg::lsu_cmd_t cmd_i,
    output logic              rsp_valid_o,
    output lsu_pkg::lsu_rsp_t rsp_o
);

    import lsu_pkg::*;

    logic [REG_ADDR_W-1:0] rs1_idx;
    logic [REG_ADDR_W-1:0] rs2_idx;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;
    logic [XLEN-1:0]       mem_addr;
    logic                  mem_we;
    logic [XLEN-1:0]       mem_wdata;
    mem_size_e             mem_size;
    logic                  mem_signed;
    logic [XLEN-1:0]       mem_rdata;

    lsu_exec #(
        .MEM_BYTES (MEM_BYTES)
    ) u_exec (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_i        (cmd_i),
        .rs1_idx_o    (rs1_idx),
        .rs2_idx_o    (rs2_idx),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .rf_we_o      (rf_we),
        .rf_waddr_o   (rf_waddr),
        .rf_wdata_o   (rf_wdata),
        .mem_addr_o   (mem_addr),
        .mem_we_o     (mem_we),
        .mem_wdata_o  (mem_wdata),
        .mem_size_o   (mem_size),
        .mem_signed_o (mem_signed),
        .mem_rdata_i  (mem_rdata),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_o        (rsp_o)
    );

    reg_file #(
        .REG_COUNT (REG_COUNT)
    ) u_reg_file (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .raddr_a_i (rs1_idx),
        .raddr_b_i (rs2_idx),
        .rdata_a_o (rs1_data),
        .rdata_b_o (rs2_data),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata)
    );

    data_memory #(
        .MEM_BYTES (MEM_BYTES)
    ) u_data_memory (
        .clk_i    (clk_i),
        .addr_i   (mem_addr),
        .we_i     (mem_we),
        .wdata_i  (mem_wdata),
        .size_i   (mem_size),
        .signed_i (mem_signed),
        .rdata_o  (mem_rdata)
    );

endmodule

//--- lsu_exec.sv
`timescale 1ns/1ps

module lsu_exec #(
    parameter int MEM_BYTES = 1024
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          cmd_valid_i,
    input  lsu_pkg::lsu_cmd_t             cmd_i,
    output logic [lsu_pkg::REG_ADDR_W-1:0] rs1_idx_o,
    output logic [lsu_pkg::REG_ADDR_W-1:0] rs2_idx_o,
    input  logic [lsu_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [lsu_pkg::XLEN-1:0]       rs2_data_i,
    output logic                          rf_we_o,
    output logic [lsu_pkg::REG_ADDR_W-1:0] rf_waddr_o,
    output logic [lsu_pkg::XLEN-1:0]       rf_wdata_o,
    output logic [lsu_pkg::XLEN-1:0]       mem_addr_o,
    output logic                          mem_we_o,
    output logic [lsu_pkg::XLEN-1:0]       mem_wdata_o,
    output lsu_pkg::mem_size_e            mem_size_o,
    output logic                          mem_signed_o,
    input  logic [lsu_pkg::XLEN-1:0]       mem_rdata_i,
    output logic                          rsp_valid_o,
    output lsu_pkg::lsu_rsp_t             rsp_o
);

    import lsu_pkg::*;

    // highest legal start address per access size
    localparam logic [XLEN-1:0] LAST_BYTE = XLEN'(MEM_BYTES - 1);
    localparam logic [XLEN-1:0] LAST_WORD = XLEN'(MEM_BYTES - 4);

    logic            s1_valid;
    lsu_cmd_t        s1_cmd;
    logic [XLEN-1:0] offset_ext;
    logic [XLEN-1:0] eff_addr;
    logic            is_load;
    logic            is_store;
    logic            is_li;
    logic            fault;
    lsu_rsp_t        rsp_next;

    // stage 1 command register
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= cmd_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmd_valid_i) begin
            s1_cmd <= cmd_i;
        end
    end

    assign rs1_idx_o  = s1_cmd.rs1;
    assign rs2_idx_o  = s1_cmd.rs2;
    assign offset_ext = {{(XLEN-16){s1_cmd.offset[15]}}, s1_cmd.offset};
    assign eff_addr   = rs1_data_i + offset_ext;

    // opcode decode
    always_comb begin
        is_load      = 1'b0;
        is_store     = 1'b0;
        is_li        = 1'b0;
        mem_size_o   = SIZE_WORD;
        mem_signed_o = 1'b0;
        case (s1_cmd.op)
            OP_LI:  is_li = 1'b1;
            OP_LB: begin
                is_load      = 1'b1;
                mem_size_o   = SIZE_BYTE;
                mem_signed_o = 1'b1;
            end
            OP_LBU: begin
                is_load    = 1'b1;
                mem_size_o = SIZE_BYTE;
            end
            OP_LW:  is_load = 1'b1;
            OP_SB: begin
                is_store   = 1'b1;
                mem_size_o = SIZE_BYTE;
            end
            OP_SW:  is_store = 1'b1;
            default: ;
        endcase
    end

    // alignment and range check, LI never faults
    always_comb begin
        if (!(is_load || is_store)) begin
            fault = 1'b0;
        end else if (mem_size_o == SIZE_WORD) begin
            fault = (eff_addr[1:0] != 2'b00) || (eff_addr > LAST_WORD);
        end else begin
            fault = (eff_addr > LAST_BYTE);
        end
    end

    assign mem_addr_o  = eff_addr;
    assign mem_wdata_o = rs2_data_i;
    assign mem_we_o    = s1_valid && is_store && !fault;

    assign rf_waddr_o = s1_cmd.rd;
    assign rf_wdata_o = is_li ? offset_ext : mem_rdata_i;
    assign rf_we_o    = s1_valid && (is_li || (is_load && !fault)) && (s1_cmd.rd != '0);

    always_comb begin
        rsp_next.rd    = s1_cmd.rd;
        rsp_next.fault = fault;
        rsp_next.addr  = is_li ? '0 : eff_addr;
        if (fault) begin
            rsp_next.data = '0;
        end else if (is_li) begin
            rsp_next.data = offset_ext;
        end else if (is_store) begin
            rsp_next.data = rs2_data_i; // echo the stored value
        end else begin
            rsp_next.data = mem_rdata_i;
        end
    end

    // response register, end of stage 1
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= s1_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (s1_valid) begin
            rsp_o <= rsp_next;
        end
    end

    // two responses in a row need two strobes in a row, two cycles earlier
    a_rsp_back_to_back: assert property (
        @(posedge clk_i) disable iff (reset_i)
        (rsp_valid_o && $past(rsp_valid_o)) |-> ($past(cmd_valid_i, 2) && $past(cmd_valid_i, 3))
    ) else $error("lsu_exec: response held without back-to-back commands");

    // a single command never writes both memory and register file
    a_we_exclusive: assert property (
        @(posedge clk_i) disable iff (reset_i) !(mem_we_o && rf_we_o)
    ) else $error("lsu_exec: memory and register write in the same cycle");

endmodule

//--- data_memory.sv
`timescale 1ns/1ps

module data_memory #(
    parameter int MEM_BYTES = 1024
) (
    input  logic                    clk_i,
    input  logic [lsu_pkg::XLEN-1:0] addr_i,    // byte address
    input  logic                    we_i,
    input  logic [lsu_pkg::XLEN-1:0] wdata_i,
    input  lsu_pkg::mem_size_e      size_i,
    input  logic                    signed_i,  // sign-extend byte loads
    output logic [lsu_pkg::XLEN-1:0] rdata_o
);

    import lsu_pkg::*;

    logic [7:0]      mem [MEM_BYTES];

    logic [XLEN-1:0] wa0;
    logic [XLEN-1:0] wa1;
    logic [XLEN-1:0] wa2;
    logic [XLEN-1:0] wa3;
    logic [XLEN-1:0] word_val;
    logic [7:0]      byte_val;

    initial begin
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem[i] = 8'h00;
        end
        $readmemh("data.mem", mem); // fills the low end only
    end

    // byte lanes of the word holding addr_i, msb first
    assign wa0 = {addr_i[XLEN-1:2], 2'd0};
    assign wa1 = {addr_i[XLEN-1:2], 2'd1};
    assign wa2 = {addr_i[XLEN-1:2], 2'd2};
    assign wa3 = {addr_i[XLEN-1:2], 2'd3};

    assign word_val = {mem[wa0], mem[wa1], mem[wa2], mem[wa3]}; // big-endian
    assign byte_val = mem[addr_i];

    always_comb begin
        if (size_i == SIZE_WORD) begin
            rdata_o = word_val;
        end else if (signed_i) begin
            rdata_o = {{(XLEN-8){byte_val[7]}}, byte_val};
        end else begin
            rdata_o = {{(XLEN-8){1'b0}}, byte_val};
        end
    end

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            if (size_i == SIZE_WORD) begin
                mem[wa0] <= wdata_i[31:24];
                mem[wa1] <= wdata_i[23:16];
                mem[wa2] <= wdata_i[15:8];
                mem[wa3] <= wdata_i[7:0];
            end else begin
                mem[addr_i] <= wdata_i[7:0]; // true byte addressing
            end
        end
    end

    // misaligned word stores must have been stopped by the fault check upstream
    a_word_write_aligned: assert property (
        @(posedge clk_i) (we_i && (size_i == SIZE_WORD)) |-> (addr_i[1:0] == 2'b00)
    ) else $error("data_memory: misaligned word write at %h", addr_i);

endmodule

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file #(
    parameter int REG_COUNT = 8
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic [lsu_pkg::REG_ADDR_W-1:0] raddr_a_i,
    input  logic [lsu_pkg::REG_ADDR_W-1:0] raddr_b_i,
    output logic [lsu_pkg::XLEN-1:0]       rdata_a_o,
    output logic [lsu_pkg::XLEN-1:0]       rdata_b_o,
    input  logic                          we_i,
    input  logic [lsu_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [lsu_pkg::XLEN-1:0]       wdata_i
);

    import lsu_pkg::*;

    logic [XLEN-1:0] regs [REG_COUNT];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin // x0 is hardwired
            regs[waddr_i] <= wdata_i;
        end
    end

    // combinational read ports, x0 reads zero
    always_comb begin
        rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
        rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];
    end

endmodule

//--- lsu_pkg.sv
package lsu_pkg;

    // data path and address width
    localparam int XLEN = 32;

    // register index width, 8 registers
    localparam int REG_ADDR_W = 3;

    typedef enum logic [2:0] {
        OP_LI  = 3'd0, // rd = sign-extended offset
        OP_LB  = 3'd1, // signed byte load
        OP_LBU = 3'd2, // unsigned byte load
        OP_LW  = 3'd3, // word load
        OP_SB  = 3'd4, // store low byte of rs2
        OP_SW  = 3'd5  // store rs2 as word
    } lsu_op_e;

    typedef enum logic {
        SIZE_BYTE = 1'b0,
        SIZE_WORD = 1'b1
    } mem_size_e;

    typedef struct packed {
        lsu_op_e                 op;
        logic [REG_ADDR_W-1:0]   rd;
        logic [REG_ADDR_W-1:0]   rs1;    // base register
        logic [REG_ADDR_W-1:0]   rs2;    // store data register
        logic signed [15:0]      offset;
    } lsu_cmd_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0]   rd;
        logic [XLEN-1:0]         data;   // load value, stored value or LI value
        logic [XLEN-1:0]         addr;   // effective address
        logic                    fault;
    } lsu_rsp_t;

endpackage
